/* cpu_config.svh */
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// Memory bytes with code in the lower half and data in the upper half
`define CPU_MEM_DEPTH   256

// Stack pointer starts at top of memory
`define CPU_SP_RESET    8'hFF

// Register file reset values
`define CPU_R0_RESET    8'h01
`define CPU_R1_RESET    8'h02
`define CPU_R2_RESET    8'h03
`define CPU_R3_RESET    8'h04

`endif

/* cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

   // Datapath bus operations
   typedef enum logic [4:0] {
      DP_ADD      = 5'b00000,
      DP_SUB      = 5'b00001,
      DP_MUL      = 5'b00010,
      DP_DIV      = 5'b00011,
      DP_XOR01    = 5'b00100,
      DP_XOR12    = 5'b00101,
      DP_XOR23    = 5'b00110,
      DP_XORPC3   = 5'b00111,
      DP_PASS     = 5'b01000,      // Any unlisted code passes data_in
      DP_SPINC    = 5'b11010,
      DP_SPDEC    = 5'b11011,
      DP_PC       = 5'b11100,
      DP_CODEADDR = 5'b11101,
      DP_DATAADDR = 5'b11110,
      DP_PCINC    = 5'b11111
   } dp_op_e;

   // Bit 2 picks bus over data_in, bits 1:0 the register
   typedef enum logic [2:0] {
      RB_IN0  = 3'b000,
      RB_IN1  = 3'b001,
      RB_IN2  = 3'b010,
      RB_IN3  = 3'b011,
      RB_BUS0 = 3'b100,
      RB_BUS1 = 3'b101,
      RB_BUS2 = 3'b110,
      RB_BUS3 = 3'b111
   } rb_sel_e;

   typedef enum logic [3:0] {
      OP_ADD   = 4'h0,
      OP_SUB   = 4'h1,
      OP_MUL   = 4'h2,
      OP_DIV   = 4'h3,
      OP_SWP01 = 4'h4,
      OP_SWP12 = 4'h5,
      OP_SWP23 = 4'h6,
      OP_XJMP  = 4'h7,
      OP_LD0   = 4'h8,
      OP_LD1   = 4'h9,
      OP_LD2   = 4'hA,
      OP_LD3   = 4'hB,
      OP_POP   = 4'hC,
      OP_UNPOP = 4'hD,
      OP_OUT   = 4'hE,
      OP_HALT  = 4'hF
   } opcode_e;

   typedef struct packed {
      logic [1:0] grp;                 // Instruction group
      logic [1:0] idx;                 // ALU function or register index
   } instr_fields_t;

   typedef union packed {
      opcode_e       op;
      instr_fields_t f;
   } instr_u;

   typedef struct packed {
      dp_op_e  op;
      logic    ir_we;
      logic    pc_we;
      rb_sel_e rb_sel;
      logic    rb_we;
      logic    sp_we;
   } dp_ctrl_t;

endpackage

`default_nettype wire

/* micro_cpu.sv */
`timescale 1ns/1ps
`default_nettype none

module micro_cpu (
   input  wire        clk,
   input  wire        nRst,
   input  wire        run,
   input  wire        load_we,
   input  wire  [7:0] load_addr,
   input  wire  [7:0] load_data,
   output logic [7:0] out_data,
   output logic       out_valid,
   output logic       halted
);

   import cpu_pkg::*;

   dp_ctrl_t   ctrl;
   instr_u     ir;
   logic [7:0] mem_rd_data;

   up_sequencer u_sequencer (
      .clk       (clk),
      .nRst      (nRst),
      .run       (run),
      .ir        (ir),
      .ctrl      (ctrl),
      .out_valid (out_valid),
      .halted    (halted)
   );

   // Bus doubles as memory address and out_data
   up_datapath u_datapath (
      .clk      (clk),
      .nRst     (nRst),
      .data_in  (mem_rd_data),
      .ctrl     (ctrl),
      .data_out (out_data),
      .ir       (ir)
   );

   program_memory u_memory (
      .clk       (clk),
      .rd_addr   (out_data),
      .rd_data   (mem_rd_data),
      .load_we   (load_we),
      .load_addr (load_addr),
      .load_data (load_data)
   );

endmodule

`default_nettype wire

/* micro_cpu_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module micro_cpu_assert (
   input wire                     clk,
   input wire                     nRst,
   input wire                     out_valid,
   input wire                     halted,
   input wire cpu_pkg::dp_ctrl_t  ctrl
);

   int fail_count = 0;

   a_out_pulse: assert property (@(posedge clk) disable iff (!nRst)
      out_valid |=> !out_valid)
   else begin
      fail_count++;
      $error("out_valid stayed high for more than one cycle");
   end

   a_halt_sticky: assert property (@(posedge clk) disable iff (!nRst)
      halted |=> halted)
   else begin
      fail_count++;
      $error("halted fell without a reset");
   end

   // Nothing may change state once halted
   a_halt_quiet: assert property (@(posedge clk) disable iff (!nRst)
      halted |-> !(ctrl.ir_we || ctrl.pc_we || ctrl.rb_we || ctrl.sp_we || out_valid))
   else begin
      fail_count++;
      $error("write enable or out_valid active while halted");
   end

endmodule

bind micro_cpu micro_cpu_assert u_assert (
   .clk       (clk),
   .nRst      (nRst),
   .out_valid (out_valid),
   .halted    (halted),
   .ctrl      (ctrl)
);

`default_nettype wire

/* program_memory.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_config.svh"

module program_memory (
   input  wire        clk,
   input  wire  [7:0] rd_addr,
   output logic [7:0] rd_data,
   input  wire        load_we,
   input  wire  [7:0] load_addr,
   input  wire  [7:0] load_data
);

   logic [7:0] mem [`CPU_MEM_DEPTH];

   // Combinational read feeds data_in in the same cycle
   assign rd_data = mem[rd_addr];

   always_ff @(posedge clk) begin
      if (load_we) begin
         mem[load_addr] <= load_data;
      end
   end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module tb_micro_cpu -f sim.f -o sim_micro_cpu

# Simulator status is not trusted, the log decides
obj_dir/sim_micro_cpu > sim.log 2>&1 || true
cat sim.log

if grep -q "Test completed successfully" sim.log; then
   echo "PASS"
   exit 0
fi
echo "FAIL"
exit 1

/* sim.f */
+incdir+.
cpu_pkg.sv
program_memory.sv
up_datapath.sv
up_sequencer.sv
micro_cpu.sv
micro_cpu_assert.sv
tb_micro_cpu.sv

/* tb_micro_cpu.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_config.svh"

module tb_micro_cpu;

   import cpu_pkg::*;

   localparam int MAX_INSTR   = 48;
   localparam int PROG_CYCLES = 5 * MAX_INSTR + 8;
   localparam int NUM_PROGS   = 6;
   localparam int HALF        = `CPU_MEM_DEPTH / 2;
   // Reset, full load and worst case run for every program plus margin
   localparam int TIMEOUT_CYCLES = NUM_PROGS * (5 + `CPU_MEM_DEPTH + PROG_CYCLES + 4) + 200;

   logic        clk;
   logic        nRst;
   logic        run;
   logic        load_we;
   logic [7:0]  load_addr;
   logic [7:0]  load_data;
   logic [7:0]  out_data;
   logic        out_valid;
   logic        halted;

   logic [7:0]  image [`CPU_MEM_DEPTH];
   logic        slot_used [HALF];
   opcode_e     prog_q [$];
   logic [7:0]  exp_q [$];
   logic [7:0]  got_q [$];
   logic        exp_halted;
   logic [31:0] rng_state = 32'h0472_3c50;
   int          err_cnt = 0;
   int          cycle_cnt = 0;

   micro_cpu DUT (
      .clk       (clk),
      .nRst      (nRst),
      .run       (run),
      .load_we   (load_we),
      .load_addr (load_addr),
      .load_data (load_data),
      .out_data  (out_data),
      .out_valid (out_valid),
      .halted    (halted)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   always @(posedge clk) begin
      cycle_cnt = cycle_cnt + 1;
      if (cycle_cnt >= TIMEOUT_CYCLES) begin
         $display("Timeout: simulation ran past %0d cycles", TIMEOUT_CYCLES);
         $display("Test failed");
         $finish;
      end
   end

   function automatic logic [7:0] rand_byte();
      rng_state = rng_state * 32'd1664525 + 32'd1013904223;
      return rng_state[23:16];
   endfunction

   task automatic check_out_data(input logic [7:0] got, input logic [7:0] exp,
                                 input string what);
      if (got !== exp) begin
         err_cnt++;
         $display("CHECK FAILED at %0d ns: %s got %02h expected %02h", $time, what, got, exp);
      end
   endtask

   task automatic check_halted(input logic got, input logic exp, input string what);
      if (got !== exp) begin
         err_cnt++;
         $display("CHECK FAILED at %0d ns: %s halted is %b expected %b", $time, what, got, exp);
      end
   endtask

   task automatic new_program();
      int i;
      prog_q.delete();
      for (i = 0; i < `CPU_MEM_DEPTH; i++) begin
         image[i] = 8'(i * 91) ^ 8'hC3;
      end
      for (i = 0; i < HALF; i++) begin
         slot_used[i] = 1'b0;
      end
   endtask

   // LD reads the data byte indexed by its already incremented pc
   task automatic emit_ld(input logic [1:0] rsel, input logic [7:0] value, output int slot);
      int n;
      n = prog_q.size();
      while (slot_used[((n + 1) / 2) % HALF]) begin
         prog_q.push_back(OP_UNPOP);      // Filler that only moves sp
         n = n + 1;
      end
      slot = HALF + ((n + 1) / 2) % HALF;
      slot_used[slot - HALF] = 1'b1;
      image[slot] = value;
      prog_q.push_back(opcode_e'({2'b10, rsel}));
   endtask

   task automatic build_code();
      int k;
      opcode_e lo;
      for (k = 0; k < prog_q.size(); k += 2) begin
         lo = (k + 1 < prog_q.size()) ? prog_q[k + 1] : OP_HALT;
         image[k / 2] = {prog_q[k], lo};  // First nibble in the high half
      end
   endtask

   // ISA reference stepping one instruction per pass
   task automatic run_model();
      logic [7:0] m [`CPU_MEM_DEPTH];
      logic [7:0] r [4];
      logic [7:0] pc;
      logic [7:0] sp;
      logic [7:0] t;
      logic [7:0] code_byte;
      opcode_e    op;
      int         n;
      m = image;
      pc = 8'h00;
      sp = `CPU_SP_RESET;
      r[0] = `CPU_R0_RESET;
      r[1] = `CPU_R1_RESET;
      r[2] = `CPU_R2_RESET;
      r[3] = `CPU_R3_RESET;
      exp_q.delete();
      exp_halted = 1'b0;
      for (n = 0; n < MAX_INSTR && !exp_halted; n++) begin
         code_byte = m[{1'b0, pc[7:1]}];
         op = opcode_e'(pc[0] ? code_byte[3:0] : code_byte[7:4]);
         pc = pc + 8'd1;
         case (op)
            OP_ADD:   r[0] = r[1] + r[2];
            OP_SUB:   r[0] = r[1] - r[2];
            OP_MUL:   r[0] = r[1] * r[2];
            OP_DIV:   r[0] = (r[2] == 8'h00) ? 8'hFF : r[1] / r[2];
            OP_SWP01: {r[0], r[1]} = {r[1], r[0]};
            OP_SWP12: {r[1], r[2]} = {r[2], r[1]};
            OP_SWP23: {r[2], r[3]} = {r[3], r[2]};
            OP_XJMP: begin
               t = pc + 8'd1;
               r[3] = t ^ r[3];                // Link value
               pc = t ^ r[3];
            end
            OP_LD0, OP_LD1, OP_LD2, OP_LD3: r[op[1:0]] = m[{1'b1, pc[7:1]}];
            OP_POP: begin
               sp = sp + 8'd1;
               r[0] = m[sp];
            end
            OP_UNPOP: sp = sp - 8'd1;
            OP_OUT:   exp_q.push_back(r[1] + r[2]);
            default:  exp_halted = 1'b1;
         endcase
      end
   endtask

   task automatic reset_cpu();
      run = 1'b0;
      load_we = 1'b0;
      nRst = 1'b0;
      repeat (5) @(posedge clk);
      #1;
      nRst = 1'b1;
   endtask

   task automatic load_image();
      int i;
      for (i = 0; i < `CPU_MEM_DEPTH; i++) begin
         load_we = 1'b1;
         load_addr = 8'(i);
         load_data = image[i];
         @(posedge clk);
         #1;
      end
      load_we = 1'b0;
   endtask

   task automatic apply_program(input string name);
      int cycles;
      int k;
      build_code();
      run_model();
      reset_cpu();
      load_image();
      run = 1'b1;
      got_q.delete();
      cycles = 0;
      while (!halted && cycles < PROG_CYCLES) begin
         @(negedge clk);
         if (out_valid) got_q.push_back(out_data);
         cycles++;
      end
      @(posedge clk);
      #1;
      run = 1'b0;
      if (got_q.size() != exp_q.size()) begin
         err_cnt++;
         $display("%s: DUT gave %0d outputs but the model expects %0d",
                  name, got_q.size(), exp_q.size());
      end
      for (k = 0; k < got_q.size() && k < exp_q.size(); k++) begin
         check_out_data(got_q[k], exp_q[k], $sformatf("%s out %0d", name, k));
      end
      check_halted(halted, exp_halted, name);
   endtask

   task automatic out_after_reset();
      new_program();
      prog_q.push_back(OP_OUT);
      prog_q.push_back(OP_HALT);
      apply_program("out_after_reset");
      if (got_q.size() > 0) check_out_data(got_q[0], 8'h05, "reset r1+r2");
   endtask

   task automatic alu_results();
      int         k;
      int         slot;
      logic [7:0] divisor;
      new_program();
      for (k = 0; k < 4; k++) begin
         emit_ld(2'd1, rand_byte(), slot);
         divisor = rand_byte();
         if (k == 3 && divisor == 8'h00) divisor = 8'h01;
         emit_ld(2'd2, divisor, slot);
         prog_q.push_back(opcode_e'(k));   // ADD, SUB, MUL, DIV
         prog_q.push_back(OP_SWP01);
         prog_q.push_back(OP_OUT);
      end
      emit_ld(2'd1, rand_byte(), slot);
      emit_ld(2'd2, 8'h00, slot);          // Divide by zero
      prog_q.push_back(OP_DIV);
      prog_q.push_back(OP_SWP01);
      prog_q.push_back(OP_OUT);
      prog_q.push_back(OP_HALT);
      apply_program("alu_ops");
      if (got_q.size() == 5) check_out_data(got_q[4], 8'hFF, "divide by zero");
   endtask

   task automatic register_swaps();
      int k;
      int slot;
      new_program();
      for (k = 0; k < 4; k++) begin
         emit_ld(2'(k), rand_byte(), slot);
      end
      prog_q.push_back(OP_OUT);
      prog_q.push_back(OP_SWP01);
      prog_q.push_back(OP_OUT);
      prog_q.push_back(OP_SWP12);
      prog_q.push_back(OP_OUT);
      prog_q.push_back(OP_SWP23);
      prog_q.push_back(OP_OUT);
      prog_q.push_back(OP_SWP12);
      prog_q.push_back(OP_OUT);
      prog_q.push_back(OP_HALT);
      apply_program("swaps");
   endtask

   task automatic exchange_jump();
      int slot;
      new_program();
      emit_ld(2'd3, 8'h00, slot);
      prog_q.push_back(OP_XJMP);
      prog_q.push_back(OP_OUT);            // Skipped
      prog_q.push_back(OP_OUT);
      image[slot] = 8'(prog_q.size());     // Jump target
      prog_q.push_back(OP_SWP23);          // Link into r2
      prog_q.push_back(OP_OUT);
      prog_q.push_back(OP_HALT);
      apply_program("xjmp");
   endtask

   task automatic stack_pop();
      int k;
      new_program();
      image[8'hFE] = rand_byte();
      image[8'hFF] = rand_byte();
      for (k = 0; k < 4; k++) begin
         if (k == 0 || k == 3) begin       // Step sp back down twice
            prog_q.push_back(OP_UNPOP);
            prog_q.push_back(OP_UNPOP);
         end
         prog_q.push_back(OP_POP);
         prog_q.push_back(OP_SWP01);
         prog_q.push_back(OP_OUT);
      end
      prog_q.push_back(OP_HALT);
      apply_program("pop");
   endtask

   task automatic stall_with_run_low();
      new_program();
      prog_q.push_back(OP_OUT);
      prog_q.push_back(OP_HALT);
      build_code();
      reset_cpu();
      load_image();
      repeat (30) begin
         @(negedge clk);
         if (out_valid) begin
            err_cnt++;
            $display("run_low: out_valid went high at %0d ns with run held low", $time);
         end
      end
      check_halted(halted, 1'b0, "run_low");
   endtask

   initial begin
      nRst = 1'b0;
      run = 1'b0;
      load_we = 1'b0;
      load_addr = 8'h00;
      load_data = 8'h00;
      @(posedge clk);
      #1;
      out_after_reset();
      alu_results();
      register_swaps();
      exchange_jump();
      stack_pop();
      stall_with_run_low();
      $display("Errors: %0d check, %0d assertion", err_cnt, DUT.u_assert.fail_count);
      if (err_cnt == 0 && DUT.u_assert.fail_count == 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* up_datapath.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_config.svh"

module up_datapath (
   input  wire                    clk,
   input  wire                    nRst,
   input  wire  [7:0]             data_in,
   input  wire  cpu_pkg::dp_ctrl_t ctrl,
   output logic [7:0]             data_out,
   output cpu_pkg::instr_u        ir
);

   import cpu_pkg::*;

   logic [7:0] pc;
   logic [7:0] sp;
   logic [7:0] r0;
   logic [7:0] r1;
   logic [7:0] r2;
   logic [7:0] r3;

   always_comb begin
      case (ctrl.op)
         DP_ADD:      data_out = r1 + r2;
         DP_SUB:      data_out = r1 - r2;
         DP_MUL:      data_out = r1 * r2;      // Low byte of product
         DP_DIV:      data_out = (r2 == 8'h00) ? 8'hFF : r1 / r2;
         DP_XOR01:    data_out = r0 ^ r1;
         DP_XOR12:    data_out = r1 ^ r2;
         DP_XOR23:    data_out = r2 ^ r3;
         DP_XORPC3:   data_out = (pc + 8'h01) ^ r3;
         DP_SPINC:    data_out = sp + 8'h01;
         DP_SPDEC:    data_out = sp - 8'h01;
         DP_PC:       data_out = pc;
         DP_CODEADDR: data_out = {1'b0, pc[7:1]};   // Byte holding current nibble
         DP_DATAADDR: data_out = {1'b1, pc[7:1]};   // Same index, upper half
         DP_PCINC:    data_out = pc + 8'h01;
         default:     data_out = data_in;
      endcase
   end

   always_ff @(posedge clk or negedge nRst) begin
      if (!nRst) begin
         pc <= 8'h00;
         sp <= `CPU_SP_RESET;
         ir <= '0;
         r0 <= `CPU_R0_RESET;
         r1 <= `CPU_R1_RESET;
         r2 <= `CPU_R2_RESET;
         r3 <= `CPU_R3_RESET;
      end else begin
         if (ctrl.ir_we) begin
            ir <= pc[0] ? data_in[3:0] : data_in[7:4];   // Even pc takes high nibble
         end
         if (ctrl.pc_we) begin
            pc <= data_out;
         end
         if (ctrl.sp_we) begin
            sp <= data_out;
         end
         if (ctrl.rb_we) begin
            case (ctrl.rb_sel)
               RB_IN0:  r0 <= data_in;
               RB_IN1:  r1 <= data_in;
               RB_IN2:  r2 <= data_in;
               RB_IN3:  r3 <= data_in;
               RB_BUS0: r0 <= data_out;
               RB_BUS1: r1 <= data_out;
               RB_BUS2: r2 <= data_out;
               RB_BUS3: r3 <= data_out;
               default: r0 <= r0;
            endcase
         end
      end
   end

endmodule

`default_nettype wire

/* up_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module up_sequencer (
   input  wire                     clk,
   input  wire                     nRst,
   input  wire                     run,
   input  wire  cpu_pkg::instr_u   ir,
   output cpu_pkg::dp_ctrl_t       ctrl,
   output logic                    out_valid,
   output logic                    halted
);

   import cpu_pkg::*;

   typedef enum logic [1:0] {
      S_FETCH,
      S_INC,
      S_EXEC,
      S_HALT
   } state_e;

   state_e     state;
   state_e     state_nxt;
   logic [1:0] step;
   logic [1:0] step_nxt;
   logic       exec_last;

   assign halted = (state == S_HALT);

   // Swaps take three steps, XJMP two, everything else one
   always_comb begin
      if (ir.f.grp == 2'b01) begin
         exec_last = (ir.op == OP_XJMP) ? (step == 2'd1) : (step == 2'd2);
      end else begin
         exec_last = (step == 2'd0);
      end
   end

   always_comb begin
      ctrl      = '0;
      ctrl.op   = DP_PC;                  // Bus shows pc when idle
      out_valid = 1'b0;
      state_nxt = state;
      step_nxt  = step;
      case (state)
         S_FETCH: begin
            if (run) begin                    // Stall here while run is low
               ctrl.op    = DP_CODEADDR;
               ctrl.ir_we = 1'b1;
               state_nxt  = S_INC;
            end
         end
         S_INC: begin
            ctrl.op    = DP_PCINC;
            ctrl.pc_we = 1'b1;
            state_nxt  = S_EXEC;
            step_nxt   = 2'd0;
         end
         S_EXEC: begin
            case (ir.f.grp)
               2'b00: begin                   // ALU result into r0
                  ctrl.op     = dp_op_e'({3'b000, ir.f.idx});
                  ctrl.rb_sel = RB_BUS0;
                  ctrl.rb_we  = 1'b1;
               end
               2'b01: begin
                  ctrl.op = dp_op_e'({3'b001, ir.f.idx});
                  if (ir.op == OP_XJMP) begin
                     if (step == 2'd0) begin
                        ctrl.rb_sel = RB_BUS3;   // Link into r3
                        ctrl.rb_we  = 1'b1;
                     end else begin
                        ctrl.pc_we  = 1'b1;
                     end
                  end else begin
                     // XOR swap targets first, second, first
                     if (step == 2'd1) begin
                        ctrl.rb_sel = rb_sel_e'({1'b1, ir.f.idx + 2'd1});
                     end else begin
                        ctrl.rb_sel = rb_sel_e'({1'b1, ir.f.idx});
                     end
                     ctrl.rb_we = 1'b1;
                  end
               end
               2'b10: begin                   // LD from upper-half data byte
                  ctrl.op     = DP_DATAADDR;
                  ctrl.rb_sel = rb_sel_e'({1'b0, ir.f.idx});
                  ctrl.rb_we  = 1'b1;
               end
               default: begin
                  case (ir.op)
                     OP_POP: begin
                        ctrl.op     = DP_SPINC;
                        ctrl.sp_we  = 1'b1;
                        ctrl.rb_sel = RB_IN0;
                        ctrl.rb_we  = 1'b1;
                     end
                     OP_UNPOP: begin
                        ctrl.op    = DP_SPDEC;
                        ctrl.sp_we = 1'b1;
                     end
                     OP_OUT: begin
                        ctrl.op   = DP_ADD;   // r1+r2 on the bus without a write
                        out_valid = 1'b1;
                     end
                     default: ;
                  endcase
               end
            endcase
            if (ir.op == OP_HALT) begin
               state_nxt = S_HALT;
            end else if (exec_last) begin
               state_nxt = S_FETCH;
               step_nxt  = 2'd0;
            end else begin
               step_nxt  = step + 2'd1;
            end
         end
         default: ;                           // Halted until reset
      endcase
   end

   always_ff @(posedge clk or negedge nRst) begin
      if (!nRst) begin
         state <= S_FETCH;
         step  <= 2'd0;
      end else begin
         state <= state_nxt;
         step  <= step_nxt;
      end
   end

endmodule

`default_nettype wire
